/* design/decode_stage.sv */
`timescale 1ns/10ps

module decode_stage (
	input  logic               clock,
	input  logic               reset,
	input  rv_pkg::word_t      ifid_pc,
	input  rv_pkg::word_t      ifid_instr,
	input  logic               stall,
	input  logic               flush_idex,
	input  rv_pkg::reg_addr_t  wb_rd,
	input  logic               wb_reg_write,
	input  rv_pkg::word_t      wb_data,
	output logic               jump,
	output rv_pkg::word_t      jump_target,
	output rv_pkg::reg_addr_t  rs1,
	output rv_pkg::reg_addr_t  rs2,
	output logic               uses_rs2,
	output rv_pkg::word_t      ex_pc,
	output rv_pkg::word_t      ex_a,
	output rv_pkg::word_t      ex_b,
	output rv_pkg::word_t      ex_imm,
	output rv_pkg::reg_addr_t  ex_rs1,
	output rv_pkg::reg_addr_t  ex_rs2,
	output rv_pkg::reg_addr_t  ex_rd,
	output rv_pkg::alu_op_t    ex_alu_op,
	output logic               ex_alu_src_imm,
	output logic               ex_reg_write,
	output logic               ex_is_load,
	output logic               ex_is_store,
	output logic               ex_is_branch
);
	import rv_pkg::*;

	word_t imm_i;
	word_t imm_s;
	word_t imm_b;
	word_t imm_j;
	word_t imm;
	word_t read_a;
	word_t read_b;
	word_t a_value;
	alu_op_t alu_op;
	logic op_known;
	logic uses_rs1;
	logic alu_src_imm;
	logic reg_write;
	logic is_load;
	logic is_store;
	logic is_branch;

	assign imm_i = {{20{ifid_instr[31]}}, ifid_instr[31:20]};
	assign imm_s = {{20{ifid_instr[31]}}, ifid_instr[31:25], ifid_instr[11:7]};
	assign imm_b = {{19{ifid_instr[31]}}, ifid_instr[31], ifid_instr[7],
		ifid_instr[30:25], ifid_instr[11:8], 1'b0};
	assign imm_j = {{11{ifid_instr[31]}}, ifid_instr[31], ifid_instr[19:12],
		ifid_instr[20], ifid_instr[30:21], 1'b0};

	always_comb begin
		op_known = 1'b1;
		uses_rs1 = 1'b1;
		uses_rs2 = 1'b0;
		alu_src_imm = 1'b0;
		reg_write = 1'b0;
		is_load = 1'b0;
		is_store = 1'b0;
		is_branch = 1'b0;
		jump = 1'b0;
		alu_op = alu_add;
		imm = imm_i;
		case (opcode_t'(ifid_instr[6:0]))
			op_r: begin
				reg_write = 1'b1;
				uses_rs2 = 1'b1;
				case (ifid_instr[14:12])
					3'b000: alu_op = ifid_instr[30] ? alu_sub : alu_add;
					3'b111: alu_op = alu_and;
					3'b110: alu_op = alu_or;
					3'b100: alu_op = alu_xor;
					3'b010: alu_op = alu_slt;
					default: begin
						op_known = 1'b0;
						reg_write = 1'b0;
					end
				endcase
			end
			op_imm: begin
				reg_write = 1'b1;
				alu_src_imm = 1'b1;
			end
			op_load: begin
				reg_write = 1'b1;
				alu_src_imm = 1'b1;
				is_load = 1'b1;
			end
			op_store: begin
				alu_src_imm = 1'b1;
				is_store = 1'b1;
				uses_rs2 = 1'b1;
				imm = imm_s;
			end
			op_branch: begin
				is_branch = 1'b1;
				uses_rs2 = 1'b1;
				alu_op = alu_sub;
				imm = imm_b;
			end
			op_jal: begin
				// link value pc + 4 goes through the alu
				reg_write = 1'b1;
				alu_src_imm = 1'b1;
				uses_rs1 = 1'b0;
				jump = 1'b1;
				imm = 32'd4;
			end
			default: begin
				op_known = 1'b0;
				uses_rs1 = 1'b0;
			end
		endcase
	end

	// unused rs1 fields read as x0 so they never stall or forward
	assign rs1 = uses_rs1 ? ifid_instr[19:15] : '0;
	assign rs2 = ifid_instr[24:20];
	assign jump_target = ifid_pc + imm_j;
	assign a_value = jump ? ifid_pc : read_a;

	reg_file i_reg_file (
		.clock       (clock),
		.reset       (reset),
		.read_addr_a (rs1),
		.read_addr_b (rs2),
		.write_addr  (wb_rd),
		.write_en    (wb_reg_write),
		.write_data  (wb_data),
		.read_a      (read_a),
		.read_b      (read_b)
	);

	// ID/EX control
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			ex_alu_src_imm <= 1'b0;
			ex_reg_write <= 1'b0;
			ex_is_load <= 1'b0;
			ex_is_store <= 1'b0;
			ex_is_branch <= 1'b0;
		end else if (stall || flush_idex) begin
			ex_alu_src_imm <= 1'b0;
			ex_reg_write <= 1'b0;
			ex_is_load <= 1'b0;
			ex_is_store <= 1'b0;
			ex_is_branch <= 1'b0;
		end else begin
			ex_alu_src_imm <= alu_src_imm;
			ex_reg_write <= reg_write;
			ex_is_load <= is_load;
			ex_is_store <= is_store;
			ex_is_branch <= is_branch;
		end
	end

	// ID/EX payload
	always_ff @(posedge clock) begin
		if (stall || flush_idex) begin
			ex_pc <= bubble_pc;
			ex_rs1 <= '0;
			ex_rs2 <= '0;
			ex_rd <= '0;
		end else begin
			ex_pc <= ifid_pc;
			ex_a <= a_value;
			ex_b <= read_b;
			ex_imm <= imm;
			ex_rs1 <= rs1;
			ex_rs2 <= rs2;
			ex_rd <= ifid_instr[11:7];
			ex_alu_op <= alu_op;
		end
	end

	assert property (@(posedge clock) disable iff (!reset) !op_known |=> !ex_reg_write);

endmodule

/* design/execute_stage.sv */
`timescale 1ns/10ps

module execute_stage (
	input  logic              clock,
	input  logic              reset,
	input  rv_pkg::word_t     ex_pc,
	input  rv_pkg::word_t     ex_a,
	input  rv_pkg::word_t     ex_b,
	input  rv_pkg::word_t     ex_imm,
	input  rv_pkg::reg_addr_t ex_rs1,
	input  rv_pkg::reg_addr_t ex_rs2,
	input  rv_pkg::reg_addr_t ex_rd,
	input  rv_pkg::alu_op_t   ex_alu_op,
	input  logic              ex_alu_src_imm,
	input  logic              ex_reg_write,
	input  logic              ex_is_load,
	input  logic              ex_is_store,
	input  logic              ex_is_branch,
	input  logic              flush_exmem,
	input  rv_pkg::reg_addr_t wb_rd,
	input  logic              wb_reg_write,
	input  rv_pkg::word_t     wb_data,
	output logic              read_en,
	output rv_pkg::word_t     ex_result,
	output rv_pkg::word_t     mem_result,
	output rv_pkg::word_t     mem_store_data,
	output rv_pkg::reg_addr_t mem_rd,
	output logic              mem_reg_write,
	output logic              mem_is_load,
	output logic              mem_is_store,
	output logic              mem_is_branch,
	output logic              mem_zero,
	output rv_pkg::word_t     mem_branch_target
);
	import rv_pkg::*;

	word_t fwd_a;
	word_t fwd_b;
	word_t alu_b;

	// the younger result in EX/MEM wins, a load there has no data yet
	function automatic word_t forward(reg_addr_t src, word_t reg_value);
		if (src != '0 && mem_reg_write && !mem_is_load && mem_rd == src) begin
			return mem_result;
		end
		if (src != '0 && wb_reg_write && wb_rd == src) begin
			return wb_data;
		end
		return reg_value;
	endfunction

	always_comb begin
		fwd_a = forward(ex_rs1, ex_a);
		fwd_b = forward(ex_rs2, ex_b);
	end

	assign alu_b = ex_alu_src_imm ? ex_imm : fwd_b;

	always_comb begin
		case (ex_alu_op)
			alu_sub: ex_result = fwd_a - alu_b;
			alu_and: ex_result = fwd_a & alu_b;
			alu_or:  ex_result = fwd_a | alu_b;
			alu_xor: ex_result = fwd_a ^ alu_b;
			alu_slt: ex_result = {{(xlen-1){1'b0}}, $signed(fwd_a) < $signed(alu_b)};
			default: ex_result = fwd_a + alu_b;
		endcase
	end

	// a load behind a taken branch must not touch memory
	assign read_en = ex_is_load && !flush_exmem;

	// EX/MEM control
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			mem_reg_write <= 1'b0;
			mem_is_load <= 1'b0;
			mem_is_store <= 1'b0;
			mem_is_branch <= 1'b0;
		end else if (flush_exmem) begin
			mem_reg_write <= 1'b0;
			mem_is_load <= 1'b0;
			mem_is_store <= 1'b0;
			mem_is_branch <= 1'b0;
		end else begin
			mem_reg_write <= ex_reg_write;
			mem_is_load <= ex_is_load;
			mem_is_store <= ex_is_store;
			mem_is_branch <= ex_is_branch;
		end
	end

	always_ff @(posedge clock) begin
		mem_result <= ex_result;
		mem_store_data <= fwd_b;
		mem_rd <= ex_rd;
		mem_zero <= (ex_result == '0);
		mem_branch_target <= ex_pc + ex_imm;
	end

endmodule

/* design/fetch_stage.sv */
`timescale 1ns/10ps

module fetch_stage #(
	parameter rv_pkg::word_t reset_pc = '0
) (
	input  logic          clock,
	input  logic          reset,
	input  rv_pkg::word_t instr,
	input  logic          stall,
	input  logic          flush_ifid,
	input  logic          jump,
	input  rv_pkg::word_t jump_target,
	input  logic          branch_taken,
	input  rv_pkg::word_t branch_target,
	output rv_pkg::word_t pc,
	output rv_pkg::word_t ifid_pc,
	output rv_pkg::word_t ifid_instr
);
	import rv_pkg::*;

	word_t next_pc;

	// branch from memory is older than the jump in decode
	always_comb begin
		if (branch_taken) begin
			next_pc = branch_target;
		end else if (jump) begin
			next_pc = jump_target;
		end else begin
			next_pc = pc + 32'd4;
		end
	end

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			pc <= reset_pc;
		end else if (!stall) begin
			pc <= next_pc;
		end
	end

	// IF/ID, a flush wins over the stall hold
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			ifid_instr <= nop_instr;
		end else if (flush_ifid) begin
			ifid_instr <= nop_instr;
		end else if (!stall) begin
			ifid_instr <= instr;
		end
	end

	always_ff @(posedge clock) begin
		if (flush_ifid) begin
			ifid_pc <= bubble_pc;
		end else if (!stall) begin
			ifid_pc <= pc;
		end
	end

endmodule

/* design/hazard_unit.sv */
`timescale 1ns/10ps

module hazard_unit (
	input  rv_pkg::reg_addr_t rs1,
	input  rv_pkg::reg_addr_t rs2,
	input  logic              uses_rs2,
	input  rv_pkg::reg_addr_t ex_rd,
	input  logic              ex_is_load,
	input  logic              jump,
	input  logic              branch_taken,
	output logic              stall,
	output logic              flush_ifid,
	output logic              flush_idex,
	output logic              flush_exmem
);

	logic load_use;

	assign load_use = ex_is_load && ex_rd != '0 &&
		(ex_rd == rs1 || (uses_rs2 && ex_rd == rs2));

	// a taken branch kills the load anyway
	assign stall = load_use && !branch_taken;

	assign flush_ifid = jump || branch_taken;
	assign flush_idex = branch_taken;
	assign flush_exmem = branch_taken;

	// decode reports x0 as rs1 for jal, so a redirect never meets a stall
	always_comb begin
		assert (!(stall && (jump || branch_taken)));
	end

endmodule

/* design/memory_stage.sv */
`timescale 1ns/10ps

module memory_stage (
	input  logic              clock,
	input  logic              reset,
	input  rv_pkg::word_t     mem_result,
	input  rv_pkg::word_t     mem_store_data,
	input  rv_pkg::reg_addr_t mem_rd,
	input  logic              mem_reg_write,
	input  logic              mem_is_load,
	input  logic              mem_is_store,
	input  logic              mem_is_branch,
	input  logic              mem_zero,
	input  rv_pkg::word_t     mem_branch_target,
	input  rv_pkg::word_t     read_data,
	output logic              write_en,
	output rv_pkg::word_t     write_data,
	output logic              branch_taken,
	output rv_pkg::word_t     branch_target,
	output rv_pkg::reg_addr_t wb_rd,
	output logic              wb_reg_write,
	output rv_pkg::word_t     wb_data
);
	import rv_pkg::*;

	word_t wb_result;
	word_t wb_load_data;
	logic wb_is_load;

	assign write_en = mem_is_store;
	assign write_data = mem_store_data;

	// beq only, equal operands leave a zero difference
	assign branch_taken = mem_is_branch && mem_zero;
	assign branch_target = mem_branch_target;

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			wb_reg_write <= 1'b0;
			wb_is_load <= 1'b0;
		end else begin
			wb_reg_write <= mem_reg_write;
			wb_is_load <= mem_is_load;
		end
	end

	// read data arrives during this stage, one cycle after read_en
	always_ff @(posedge clock) begin
		wb_rd <= mem_rd;
		wb_result <= mem_result;
		wb_load_data <= read_data;
	end

	assign wb_data = wb_is_load ? wb_load_data : wb_result;

	assert property (@(posedge clock) disable iff (!reset) !(write_en && branch_taken));

endmodule

/* design/pipe_cpu.sv */
`timescale 1ns/10ps

module pipe_cpu #(
	parameter rv_pkg::word_t reset_pc = '0
) (
	input  logic          clock,
	input  logic          reset,
	input  rv_pkg::word_t instr,
	input  rv_pkg::word_t read_data,
	output rv_pkg::word_t pc,
	output rv_pkg::word_t data_addr,
	output logic          read_en,
	output logic          write_en,
	output rv_pkg::word_t write_data
);
	import rv_pkg::*;

	word_t ifid_pc;
	word_t ifid_instr;
	logic jump;
	word_t jump_target;
	reg_addr_t rs1;
	reg_addr_t rs2;
	logic uses_rs2;
	word_t ex_pc;
	word_t ex_a;
	word_t ex_b;
	word_t ex_imm;
	reg_addr_t ex_rs1;
	reg_addr_t ex_rs2;
	reg_addr_t ex_rd;
	alu_op_t ex_alu_op;
	logic ex_alu_src_imm;
	logic ex_reg_write;
	logic ex_is_load;
	logic ex_is_store;
	logic ex_is_branch;
	word_t ex_result;
	word_t mem_result;
	word_t mem_store_data;
	reg_addr_t mem_rd;
	logic mem_reg_write;
	logic mem_is_load;
	logic mem_is_store;
	logic mem_is_branch;
	logic mem_zero;
	word_t mem_branch_target;
	logic branch_taken;
	word_t branch_target;
	reg_addr_t wb_rd;
	logic wb_reg_write;
	word_t wb_data;
	logic stall;
	logic flush_ifid;
	logic flush_idex;
	logic flush_exmem;

	// loads address from execute, stores from memory
	assign data_addr = read_en ? ex_result : mem_result;

	fetch_stage #(
		.reset_pc (reset_pc)
	) i_fetch (
		.clock, .reset, .instr, .stall, .flush_ifid, .jump, .jump_target,
		.branch_taken, .branch_target, .pc, .ifid_pc, .ifid_instr
	);

	decode_stage i_decode (
		.clock, .reset, .ifid_pc, .ifid_instr, .stall, .flush_idex,
		.wb_rd, .wb_reg_write, .wb_data, .jump, .jump_target, .rs1, .rs2, .uses_rs2,
		.ex_pc, .ex_a, .ex_b, .ex_imm, .ex_rs1, .ex_rs2, .ex_rd, .ex_alu_op,
		.ex_alu_src_imm, .ex_reg_write, .ex_is_load, .ex_is_store, .ex_is_branch
	);

	execute_stage i_execute (
		.clock, .reset, .ex_pc, .ex_a, .ex_b, .ex_imm, .ex_rs1, .ex_rs2, .ex_rd,
		.ex_alu_op, .ex_alu_src_imm, .ex_reg_write, .ex_is_load, .ex_is_store,
		.ex_is_branch, .flush_exmem, .wb_rd, .wb_reg_write, .wb_data, .read_en,
		.ex_result, .mem_result, .mem_store_data, .mem_rd, .mem_reg_write,
		.mem_is_load, .mem_is_store, .mem_is_branch, .mem_zero, .mem_branch_target
	);

	memory_stage i_memory (
		.clock, .reset, .mem_result, .mem_store_data, .mem_rd, .mem_reg_write,
		.mem_is_load, .mem_is_store, .mem_is_branch, .mem_zero, .mem_branch_target,
		.read_data, .write_en, .write_data, .branch_taken, .branch_target,
		.wb_rd, .wb_reg_write, .wb_data
	);

	hazard_unit i_hazard (
		.rs1, .rs2, .uses_rs2, .ex_rd, .ex_is_load, .jump, .branch_taken,
		.stall, .flush_ifid, .flush_idex, .flush_exmem
	);

endmodule

/* design/reg_file.sv */
`timescale 1ns/10ps

module reg_file (
	input  logic              clock,
	input  logic              reset,
	input  rv_pkg::reg_addr_t read_addr_a,
	input  rv_pkg::reg_addr_t read_addr_b,
	input  rv_pkg::reg_addr_t write_addr,
	input  logic              write_en,
	input  rv_pkg::word_t     write_data,
	output rv_pkg::word_t     read_a,
	output rv_pkg::word_t     read_b
);
	import rv_pkg::*;

	word_t regs [32];

	function automatic word_t read_port(reg_addr_t addr);
		// writeback in this cycle is seen by decode
		if (write_en && write_addr != '0 && write_addr == addr) begin
			return write_data;
		end
		return regs[addr];
	endfunction

	// x0 is cleared by reset and never written
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (write_en && write_addr != '0) begin
			regs[write_addr] <= write_data;
		end
	end

	always_comb begin
		read_a = read_port(read_addr_a);
		read_b = read_port(read_addr_b);
	end

	assert property (@(posedge clock) disable iff (!reset)
		read_addr_a == '0 |-> read_a == '0);

endmodule

/* design/rv_pkg.sv */
package rv_pkg;

	// datapath width
	localparam int xlen = 32;

	typedef logic [4:0] reg_addr_t;
	typedef logic [xlen-1:0] word_t;

	// major opcodes, instr[6:0]
	typedef enum logic [6:0] {
		op_r      = 7'b0110011,
		op_imm    = 7'b0010011,
		op_load   = 7'b0000011,
		op_store  = 7'b0100011,
		op_branch = 7'b1100011,
		op_jal    = 7'b1101111
	} opcode_t;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt
	} alu_op_t;

	// addi x0, x0, 0
	localparam word_t nop_instr = 32'h0000_0013;

	// pc of a slot that holds no real instruction
	localparam word_t bubble_pc = 32'hffff_ffff;

endpackage

/* pipe_cpu.f */
+incdir+sim
design/rv_pkg.sv
design/reg_file.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/memory_stage.sv
design/hazard_unit.sv
design/pipe_cpu.sv
sim/tb_pipe_cpu.sv

/* run_sim.sh */
#!/bin/sh
# build with verilator, run, then decide from the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_pipe_cpu -f pipe_cpu.f \
	|| { echo "verilator build failed"; exit 1; }
./obj_dir/Vtb_pipe_cpu > sim.log 2>&1
cat sim.log
grep -q "Test FAILED" sim.log && exit 1
grep -q "Test OK" sim.log || exit 1
exit 0

/* sim/tb_programs.svh */
localparam int num_programs = 5;
localparam int code_words = 32;
localparam int data_words = 64;
localparam int max_stores = 8;

string program_name [num_programs];
word_t program_code [num_programs][code_words];
word_t program_data [num_programs][data_words];
word_t store_addr [num_programs][max_stores];
word_t store_value [num_programs][max_stores];
int store_total [num_programs];
int load_total [num_programs];
int slots [num_programs];

// rv32i encodings
function automatic word_t r_format(int funct7, int funct3, int rd, int rs1, int rs2);
	return {7'(funct7), 5'(rs2), 5'(rs1), 3'(funct3), 5'(rd), 7'b0110011};
endfunction

function automatic word_t addi_instr(int rd, int rs1, int imm);
	return {12'(imm), 5'(rs1), 3'b000, 5'(rd), 7'b0010011};
endfunction

function automatic word_t lw_instr(int rd, int rs1, int imm);
	return {12'(imm), 5'(rs1), 3'b010, 5'(rd), 7'b0000011};
endfunction

function automatic word_t sw_instr(int rs2, int rs1, int imm);
	logic [11:0] i;
	i = 12'(imm);
	return {i[11:5], 5'(rs2), 5'(rs1), 3'b010, i[4:0], 7'b0100011};
endfunction

function automatic word_t beq_instr(int rs1, int rs2, int offset);
	logic [12:0] o;
	o = 13'(offset);
	return {o[12], o[10:5], 5'(rs2), 5'(rs1), 3'b000, o[4:1], o[11], 7'b1100011};
endfunction

function automatic word_t jal_instr(int rd, int offset);
	logic [20:0] o;
	o = 21'(offset);
	return {o[20], o[10:1], o[11], o[19:12], 5'(rd), 7'b1101111};
endfunction

task automatic put_instr(int p, word_t word);
	program_code[p][slots[p]] = word;
	slots[p] = slots[p] + 1;
endtask

task automatic expect_store(int p, word_t addr, word_t value);
	store_addr[p][store_total[p]] = addr;
	store_value[p][store_total[p]] = value;
	store_total[p] = store_total[p] + 1;
endtask

task automatic build_programs();
	word_t state;
	word_t v [10];
	word_t link;
	logic [11:0] ia;
	logic [11:0] ib;
	for (int p = 0; p < num_programs; p++) begin
		slots[p] = 0;
		store_total[p] = 0;
		load_total[p] = 0;
		for (int i = 0; i < code_words; i++) begin
			program_code[p][i] = nop_instr;
		end
		// byte address in the low half
		for (int i = 0; i < data_words; i++) begin
			program_data[p][i] = 32'hda7a_0000 | (32'(i) << 2);
		end
	end

	program_name[0] = "reset_and_store";
	put_instr(0, addi_instr(1, 0, 85));
	put_instr(0, sw_instr(1, 0, 32));
	put_instr(0, addi_instr(2, 1, 1));
	put_instr(0, sw_instr(2, 0, 36));
	expect_store(0, 32'd32, 32'd85);
	expect_store(0, 32'd36, 32'd86);

	// dependent chain on random immediates
	program_name[1] = "alu_forwarding";
	state = xorshift(32'd46);
	ia = state[11:0];
	state = xorshift(state);
	ib = state[11:0];
	v[1] = {{20{ia[11]}}, ia};
	v[2] = v[1] + {{20{ib[11]}}, ib};
	v[3] = v[1] + v[2];
	v[4] = v[1] - v[3];
	v[5] = v[4] & v[2];
	v[6] = v[5] | v[3];
	v[7] = v[6] ^ v[4];
	v[8] = ($signed(v[7]) < $signed(v[1])) ? 32'd1 : 32'd0;
	v[9] = ($signed(v[1]) < $signed(v[7])) ? 32'd1 : 32'd0;
	put_instr(1, addi_instr(1, 0, int'(ia)));
	put_instr(1, addi_instr(2, 1, int'(ib)));
	put_instr(1, r_format(0, 0, 3, 1, 2));
	put_instr(1, r_format(32, 0, 4, 1, 3));
	put_instr(1, r_format(0, 7, 5, 4, 2));
	put_instr(1, r_format(0, 6, 6, 5, 3));
	put_instr(1, r_format(0, 4, 7, 6, 4));
	put_instr(1, r_format(0, 2, 8, 7, 1));
	put_instr(1, r_format(0, 2, 9, 1, 7));
	for (int r = 3; r <= 9; r++) begin
		put_instr(1, sw_instr(r, 0, 4 * (r - 3)));
		expect_store(1, 32'(4 * (r - 3)), v[r]);
	end

	// lw x2 feeds rs1 of the add and lw x4 feeds rs2 of the sw
	program_name[2] = "load_use";
	program_data[2][4] = 32'h1234_5678;
	program_data[2][5] = 32'h0bad_f00d;
	put_instr(2, addi_instr(1, 0, 127));
	put_instr(2, lw_instr(2, 0, 16));
	put_instr(2, r_format(0, 0, 3, 2, 1));
	put_instr(2, sw_instr(3, 0, 64));
	put_instr(2, addi_instr(5, 0, 3));
	put_instr(2, lw_instr(4, 0, 20));
	put_instr(2, sw_instr(4, 0, 68));
	expect_store(2, 32'd64, program_data[2][4] + 32'd127);
	expect_store(2, 32'd68, program_data[2][5]);
	load_total[2] = 2;

	program_name[3] = "branches";
	put_instr(3, addi_instr(1, 0, 5));
	put_instr(3, addi_instr(2, 0, 5));
	put_instr(3, addi_instr(3, 0, 7));
	put_instr(3, beq_instr(1, 3, 8));
	put_instr(3, sw_instr(3, 0, 0));
	put_instr(3, beq_instr(1, 2, 16));
	put_instr(3, sw_instr(1, 0, 4));
	put_instr(3, sw_instr(2, 0, 8));
	put_instr(3, sw_instr(3, 0, 12));
	put_instr(3, sw_instr(2, 0, 16));
	expect_store(3, 32'd0, 32'd7);
	expect_store(3, 32'd16, 32'd5);

	program_name[4] = "jal_link";
	put_instr(4, addi_instr(1, 0, 9));
	link = reset_pc + 32'(4 * slots[4]) + 32'd4;
	put_instr(4, jal_instr(5, 8));
	put_instr(4, sw_instr(1, 0, 0));
	put_instr(4, sw_instr(5, 0, 4));
	put_instr(4, sw_instr(1, 0, 8));
	expect_store(4, 32'd4, link);
	expect_store(4, 32'd8, 32'd9);

	// park every program in a jump to itself
	for (int p = 0; p < num_programs; p++) begin
		put_instr(p, jal_instr(0, 0));
	end
endtask

/* sim/tb_pipe_cpu.sv */
`timescale 1ns/10ps

module tb_pipe_cpu;
	import rv_pkg::*;

	localparam word_t reset_pc = 32'h0000_0200;
	localparam int run_limit = 200;

	logic clock = 1'b0;
	logic reset;
	word_t instr;
	word_t read_data = '0;
	word_t pc;
	word_t data_addr;
	logic read_en;
	logic write_en;
	word_t write_data;

	int current;
	int stores_seen;
	int loads_seen;
	logic load_pending;
	word_t load_addr;
	word_t fetch_offset;

	function automatic word_t xorshift(word_t x);
		word_t y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	`include "tb_programs.svh"

	word_t imem [code_words];
	word_t dmem [data_words];
	word_t dmem_image [data_words];

	pipe_cpu #(
		.reset_pc (reset_pc)
	) i_dut (
		.clock      (clock),
		.reset      (reset),
		.instr      (instr),
		.read_data  (read_data),
		.pc         (pc),
		.data_addr  (data_addr),
		.read_en    (read_en),
		.write_en   (write_en),
		.write_data (write_data)
	);

	always #2 clock = ~clock;

	// past the program image fetch sees nops
	assign fetch_offset = pc - reset_pc;
	assign instr = (fetch_offset < 32'd128) ? imem[fetch_offset[6:2]] : nop_instr;

	task automatic check_value(string name, word_t expected, word_t actual);
		if (expected !== actual) begin
			$display("FAIL %s expected %h actual %h", name, expected, actual);
			$display("Test FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic abort_run(string reason);
		$display("%s", reason);
		$display("Test FAILED");
		$fatal(1, "run aborted");
	endtask

	// data memory model with stores checked in program order
	always @(negedge clock) begin
		if (!reset) begin
			for (int i = 0; i < data_words; i++) begin
				dmem[i] = dmem_image[i];
			end
			stores_seen = 0;
			loads_seen = 0;
			load_pending = 1'b0;
		end else begin
			if (write_en) begin
				if (stores_seen >= store_total[current]) begin
					abort_run($sformatf("%s wrote %h to %h after its last expected store",
						program_name[current], write_data, data_addr));
				end else begin
					check_value($sformatf("%s store %0d address", program_name[current],
						stores_seen), store_addr[current][stores_seen], data_addr);
					check_value($sformatf("%s store %0d value", program_name[current],
						stores_seen), store_value[current][stores_seen], write_data);
					dmem[data_addr[7:2]] = write_data;
					stores_seen = stores_seen + 1;
				end
			end
			// read data follows read_en by one cycle
			if (load_pending) begin
				read_data = dmem[load_addr[7:2]];
			end
			if (read_en) begin
				loads_seen = loads_seen + 1;
			end
			load_pending = read_en;
			load_addr = data_addr;
		end
	end

	task automatic run_program(int p);
		@(negedge clock);
		reset = 1'b0;
		current = p;
		for (int i = 0; i < code_words; i++) begin
			imem[i] = program_code[p][i];
		end
		for (int i = 0; i < data_words; i++) begin
			dmem_image[i] = program_data[p][i];
		end
		repeat (5) @(negedge clock);
		reset = 1'b1;
		check_value({program_name[p], " reset pc"}, reset_pc, pc);
		for (int c = 0; c < run_limit && stores_seen < store_total[p]; c++) begin
			@(posedge clock);
		end
		if (stores_seen < store_total[p]) begin
			abort_run($sformatf("timeout in %s with %0d of %0d stores seen",
				program_name[p], stores_seen, store_total[p]));
		end
		// a few more cycles to catch stray stores
		repeat (10) @(posedge clock);
		check_value({program_name[p], " read strobes"}, 32'(load_total[p]),
			32'(loads_seen));
	endtask

	initial begin
		reset = 1'b0;
		current = 0;
		build_programs();
		for (int p = 0; p < num_programs; p++) begin
			run_program(p);
		end
		$display("Test OK");
		$finish;
	end

endmodule
